/* hdl/fp_cfg.svh */
// number format widths and bus widths; three words per number is assumed wherever lp indexes
`ifndef FP_CFG_SVH
`define FP_CFG_SVH

// number format: fraction mantissa then exponent, both two's complement
`define FP_MANT_W 40
`define FP_EXP_W 8
`define FP_EXP_MAX 127
`define FP_EXP_MIN (-128)

// memory side
`define FP_WORDS 3
`define FP_WORD_W 16
`define FP_ADDR_W 16

// word counter width, must hold FP_WORDS-1
`define FP_LP_W 2

`endif

/* hdl/fp_ctl_if.sv */
// datapath commands; do_* are one-cycle pulses, ld_* are levels held while a read is open
`timescale 1ns/1ps
`include "fp_cfg.svh"

interface fp_ctl_if;

	// commands from the sequencer
	logic ld_acc_word;
	logic ld_arg_word;
	logic do_align;
	logic do_add;
	logic do_norm;
	logic sub;

	// status back from the datapath
	logic norm_done;
	logic ovf;
	logic [`FP_WORD_W-1:0] word_out;

	modport seq (output ld_acc_word, ld_arg_word, do_align, do_add, do_norm, sub,
		input norm_done, ovf);
	modport dp (input ld_acc_word, ld_arg_word, do_align, do_add, do_norm, sub,
		output norm_done, ovf, word_out);

endinterface

/* hdl/fp_datapath.sv */
// accumulator and argument; no rounding, ovf belongs to the accumulator and a load clears it
`timescale 1ns/1ps
`include "fp_cfg.svh"

module fp_datapath (
	input  logic                  clk_sys,
	input  logic                  _0_f,
	fp_ctl_if.dp                  cif,
	input  logic [`FP_LP_W-1:0]   lp,
	input  logic [`FP_WORD_W-1:0] mem_rdata,
	output logic [`FP_WORD_W-1:0] mem_wdata,
	output logic                  ovf
);

	localparam int MW = `FP_MANT_W;
	localparam int EW = `FP_EXP_W;

	fp_pkg::fp_num_u acc;
	fp_pkg::fp_num_u arg;
	logic ovf_q;

	logic [EW:0] exp_diff;
	logic [EW:0] shamt;
	logic acc_big;
	logic [MW-1:0] small_m;
	logic [MW-1:0] small_sh;
	logic [MW:0] arg_ext;
	logic [MW:0] sum;
	logic carry;
	logic signed [EW+1:0] exp_up;
	logic signed [EW+1:0] exp_dn;
	logic norm_done;

	// ----------------------------------------------------------
	// align, add and normalize terms
	// ----------------------------------------------------------
	always_comb begin
		exp_diff = {acc.fields.exp[EW-1], acc.fields.exp} - {arg.fields.exp[EW-1], arg.fields.exp};
		acc_big = ~exp_diff[EW];
		shamt = acc_big ? exp_diff : -exp_diff;
		small_m = acc_big ? arg.fields.mant : acc.fields.mant;
		// shifted fully out, only sign bits remain
		if (shamt >= MW)
			small_sh = {MW{small_m[MW-1]}};
		else
			small_sh = $signed(small_m) >>> shamt;

		// one guard bit above the mantissa
		arg_ext = {arg.fields.mant[MW-1], arg.fields.mant};
		sum = {acc.fields.mant[MW-1], acc.fields.mant} + (cif.sub ? -arg_ext : arg_ext);
		carry = sum[MW] ^ sum[MW-1];

		exp_up = {{2{acc.fields.exp[EW-1]}}, acc.fields.exp} + 1'b1;
		exp_dn = {{2{acc.fields.exp[EW-1]}}, acc.fields.exp} - 1'b1;
	end

	assign norm_done = (acc.fields.mant[MW-1] != acc.fields.mant[MW-2]) || (acc.words == '0);

	// ----------------------------------------------------------
	// accumulator
	// ----------------------------------------------------------
	always_ff @(posedge clk_sys or posedge _0_f) begin
		if (_0_f) begin
			acc <= '0;
			ovf_q <= 1'b0;
		end else if (cif.ld_acc_word) begin
			acc.words[lp] <= mem_rdata;
			ovf_q <= 1'b0;
		end else if (cif.do_align) begin
			ovf_q <= 1'b0;
			if (!acc_big) begin
				acc.fields.mant <= small_sh;
				acc.fields.exp <= arg.fields.exp;
			end
		end else if (cif.do_add) begin
			if (carry) begin
				acc.fields.mant <= sum[MW:1];
				acc.fields.exp <= exp_up[EW-1:0];
				ovf_q <= (exp_up > `FP_EXP_MAX);
			end else begin
				acc.fields.mant <= sum[MW-1:0];
			end
		end else if (cif.do_norm && !norm_done) begin
			// zero mantissa or exponent underflow gives the zero number
			if (acc.fields.mant == '0 || exp_dn < `FP_EXP_MIN) begin
				acc <= '0;
			end else begin
				acc.fields.mant <= {acc.fields.mant[MW-2:0], 1'b0};
				acc.fields.exp <= exp_dn[EW-1:0];
			end
		end
	end

	// argument, assembled word by word
	always_ff @(posedge clk_sys) begin
		if (cif.ld_arg_word) begin
			arg.words[lp] <= mem_rdata;
		end else if (cif.do_align && acc_big) begin
			arg.fields.mant <= small_sh;
			arg.fields.exp <= acc.fields.exp;
		end
	end

	assign cif.norm_done = norm_done;
	assign cif.ovf = ovf_q;
	assign cif.word_out = acc.words[lp];
	assign mem_wdata = cif.word_out;
	assign ovf = ovf_q;

endmodule

/* hdl/fp_lp_counter.sv */
// word counter; the sequencer must not advance it past the last word of a number
`timescale 1ns/1ps
`include "fp_cfg.svh"

module fp_lp_counter (
	input  logic                clk_sys,
	input  logic                _0_f,
	input  logic                lp_clr,
	input  logic                lp_inc,
	output logic [`FP_LP_W-1:0] lp,
	output logic                lp_last
);

	localparam logic [`FP_LP_W-1:0] LP_LAST = `FP_LP_W'(`FP_WORDS - 1);

	always_ff @(posedge clk_sys or posedge _0_f) begin
		if (_0_f) begin
			lp <= '0;
		end else if (lp_clr) begin
			lp <= '0;
		end else if (lp_inc) begin
			lp <= lp + 1'b1;
		end
	end

	// last word of the number
	assign lp_last = (lp == LP_LAST);

	a_lp_range: assert property (@(posedge clk_sys) disable iff (_0_f) lp < `FP_WORDS);

endmodule

/* hdl/fp_pkg.sv */
// opcode and number views; the words view relies on mantissa+exponent equal to three words
`include "fp_cfg.svh"

package fp_pkg;

	// job opcodes carried by the start strobe
	typedef enum logic [1:0] {
		FP_LOAD  = 2'd0,
		FP_STORE = 2'd1,
		FP_ADD   = 2'd2,
		FP_SUB   = 2'd3
	} fp_op_t;

	// arithmetic view of a number
	typedef struct packed {
		logic [`FP_MANT_W-1:0] mant;
		logic [`FP_EXP_W-1:0]  exp;
	} fp_fields_t;

	// one 48-bit number, seen as memory words or as fields
	// word 0 is the high mantissa word
	typedef union packed {
		logic [0:`FP_WORDS-1][`FP_WORD_W-1:0] words;
		fp_fields_t                           fields;
	} fp_num_u;

endpackage

/* hdl/fp_sequencer.sv */
// job FSM; start strobes while busy are dropped, ekc_fp marks the last strob2 of a job
`timescale 1ns/1ps
`include "fp_cfg.svh"

module fp_sequencer (
	input  logic                  clk_sys,
	input  logic                  _0_f,
	input  logic                  efp,
	input  fp_pkg::fp_op_t        op,
	input  logic [`FP_ADDR_W-1:0] arg_addr,
	input  logic [`FP_LP_W-1:0]   lp,
	input  logic                  lp_last,
	output logic                  lp_clr,
	output logic                  lp_inc,
	fp_strobe_if.seq              sif,
	fp_ctl_if.seq                 cif,
	output logic [`FP_ADDR_W-1:0] mem_addr,
	output logic                  ekc_fp,
	output logic                  busy
);

	// one-hot bit positions
	localparam int S_IDLE  = 0;
	localparam int S_XFER  = 1;
	localparam int S_ALIGN = 2;
	localparam int S_ADD   = 3;
	localparam int S_NORM  = 4;
	localparam int S_END   = 5;

	localparam logic [5:0] ST_IDLE  = 6'b000001;
	localparam logic [5:0] ST_XFER  = 6'b000010;
	localparam logic [5:0] ST_ALIGN = 6'b000100;
	localparam logic [5:0] ST_ADD   = 6'b001000;
	localparam logic [5:0] ST_NORM  = 6'b010000;
	localparam logic [5:0] ST_END   = 6'b100000;

	logic [5:0] st;
	logic [5:0] st_nx;
	fp_pkg::fp_op_t op_q;
	fp_pkg::fp_op_t op_nx;
	logic [`FP_ADDR_W-1:0] addr_q;
	logic start;
	logic arith;

	assign start = st[S_IDLE] & efp;
	assign arith = (op_q == fp_pkg::FP_ADD) | (op_q == fp_pkg::FP_SUB);

	// ----------------------------------------------------------
	// next state, taken at strob2
	// ----------------------------------------------------------
	always_comb begin
		st_nx = st;
		if (start) begin
			st_nx = ST_XFER;
		end else if (sif.strob2) begin
			case (1'b1)
				st[S_XFER]:  if (lp_last) st_nx = arith ? ST_ALIGN : ST_IDLE;
				st[S_ALIGN]: st_nx = ST_ADD;
				// an overflowed sum is already normalized
				st[S_ADD]:   st_nx = cif.ovf ? ST_END : ST_NORM;
				st[S_NORM]:  if (cif.norm_done) st_nx = ST_END;
				st[S_END]:   st_nx = ST_IDLE;
				default:     st_nx = ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_sys or posedge _0_f) begin
		if (_0_f) begin
			st <= ST_IDLE;
			op_q <= fp_pkg::FP_LOAD;
		end else begin
			st <= st_nx;
			if (start)
				op_q <= op;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (start)
			addr_q <= arg_addr;
	end

	// ----------------------------------------------------------
	// step requests and word counter
	// ----------------------------------------------------------
	// opcode is not latched yet in the start cycle
	assign op_nx = st[S_IDLE] ? op : op_q;

	assign sif.step_go  = start | (sif.strob2 & ~st_nx[S_IDLE]);
	assign sif.step_mem = st_nx[S_XFER];
	assign sif.step_we  = (op_nx == fp_pkg::FP_STORE);

	assign lp_clr = start;
	assign lp_inc = sif.strob2 & st[S_XFER] & ~lp_last;

	assign mem_addr = addr_q + {{(`FP_ADDR_W - `FP_LP_W){1'b0}}, lp};

	// datapath commands
	assign cif.ld_acc_word = st[S_XFER] & (op_q == fp_pkg::FP_LOAD) & sif.mem_rd;
	assign cif.ld_arg_word = st[S_XFER] & arith & sif.mem_rd;
	assign cif.do_align    = st[S_ALIGN] & sif.strob1;
	assign cif.do_add      = st[S_ADD] & sif.strob1;
	assign cif.do_norm     = st[S_NORM] & sif.strob1;
	assign cif.sub         = (op_q == fp_pkg::FP_SUB);

	assign ekc_fp = sif.strob2 & ~st[S_IDLE] & st_nx[S_IDLE];
	assign busy   = ~st[S_IDLE];

	// a step never completes while idle
	a_strob2_busy: assert property (@(posedge clk_sys) disable iff (_0_f)
		sif.strob2 |-> !st[S_IDLE]);

endmodule

/* hdl/fp_strobe_if.sv */
// step handshake between sequencer and strobe generator; step_mem/step_we only matter with step_go
`timescale 1ns/1ps

interface fp_strobe_if;

	// sequencer side
	logic step_go;
	logic step_mem;
	logic step_we;

	// generator side
	logic strob1;
	logic strob2;
	logic mem_rd;
	logic mem_wr;

	modport seq (output step_go, step_mem, step_we, input strob1, strob2, mem_rd);
	modport gen (input step_go, step_mem, step_we, output strob1, strob2, mem_rd, mem_wr);

endinterface

/* hdl/fp_strobgen.sv */
// strobe phase pair per step; memory requests stay up until mem_ok, with no timeout
`timescale 1ns/1ps

module fp_strobgen (
	input  logic      clk_sys,
	input  logic      _0_f,
	fp_strobe_if.gen  sif,
	input  logic      mem_ok
);

	localparam logic [1:0] PH_IDLE = 2'd0;
	localparam logic [1:0] PH_1    = 2'd1;
	localparam logic [1:0] PH_WAIT = 2'd2;
	localparam logic [1:0] PH_2    = 2'd3;

	logic [1:0] ph;
	logic rd_q;
	logic wr_q;

	// ----------------------------------------------------------
	// phase machine
	// ----------------------------------------------------------
	always_ff @(posedge clk_sys or posedge _0_f) begin
		if (_0_f) begin
			ph <= PH_IDLE;
			rd_q <= 1'b0;
			wr_q <= 1'b0;
		end else begin
			case (ph)
				PH_IDLE, PH_2: begin
					if (sif.step_go) begin
						ph <= PH_1;
						// request rises together with strob1
						rd_q <= sif.step_mem & ~sif.step_we;
						wr_q <= sif.step_mem & sif.step_we;
					end else begin
						ph <= PH_IDLE;
					end
				end
				PH_1, PH_WAIT: begin
					if (!(rd_q || wr_q) || mem_ok) begin
						ph <= PH_2;
						rd_q <= 1'b0;
						wr_q <= 1'b0;
					end else begin
						ph <= PH_WAIT;
					end
				end
				default: ph <= PH_IDLE;
			endcase
		end
	end

	assign sif.strob1 = (ph == PH_1);
	assign sif.strob2 = (ph == PH_2);
	assign sif.mem_rd = rd_q;
	assign sif.mem_wr = wr_q;

	// a new step is only taken between steps
	a_step_go_phase: assert property (@(posedge clk_sys) disable iff (_0_f)
		sif.step_go |-> (ph == PH_IDLE || ph == PH_2));

endmodule

/* hdl/fpu_ctl_top.sv */
// FPU control top; one job at a time, memory is a single level-request port with mem_ok
`timescale 1ns/1ps
`include "fp_cfg.svh"

module fpu_ctl_top (
	input  logic                  clk_sys,
	input  logic                  _0_f,
	input  logic                  efp,
	input  fp_pkg::fp_op_t        op,
	input  logic [`FP_ADDR_W-1:0] arg_addr,
	input  logic [`FP_WORD_W-1:0] mem_rdata,
	input  logic                  mem_ok,
	output logic                  mem_rd,
	output logic                  mem_wr,
	output logic [`FP_ADDR_W-1:0] mem_addr,
	output logic [`FP_WORD_W-1:0] mem_wdata,
	output logic                  ekc_fp,
	output logic                  busy,
	output logic                  ovf
);

	fp_strobe_if sif ();
	fp_ctl_if    cif ();

	logic [`FP_LP_W-1:0] lp;
	logic lp_last;
	logic lp_clr;
	logic lp_inc;

	fp_strobgen u_strobgen (
		.clk_sys (clk_sys),
		._0_f    (_0_f),
		.sif     (sif.gen),
		.mem_ok  (mem_ok)
	);

	fp_lp_counter u_lp (
		.clk_sys (clk_sys),
		._0_f    (_0_f),
		.lp_clr  (lp_clr),
		.lp_inc  (lp_inc),
		.lp      (lp),
		.lp_last (lp_last)
	);

	fp_sequencer u_seq (
		.clk_sys  (clk_sys),
		._0_f     (_0_f),
		.efp      (efp),
		.op       (op),
		.arg_addr (arg_addr),
		.lp       (lp),
		.lp_last  (lp_last),
		.lp_clr   (lp_clr),
		.lp_inc   (lp_inc),
		.sif      (sif.seq),
		.cif      (cif.seq),
		.mem_addr (mem_addr),
		.ekc_fp   (ekc_fp),
		.busy     (busy)
	);

	fp_datapath u_dp (
		.clk_sys   (clk_sys),
		._0_f      (_0_f),
		.cif       (cif.dp),
		.lp        (lp),
		.mem_rdata (mem_rdata),
		.mem_wdata (mem_wdata),
		.ovf       (ovf)
	);

	assign mem_rd = sif.mem_rd;
	assign mem_wr = sif.mem_wr;

endmodule

/* project.f */
+incdir+hdl
hdl/fp_pkg.sv
hdl/fp_strobe_if.sv
hdl/fp_ctl_if.sv
hdl/fp_strobgen.sv
hdl/fp_lp_counter.sv
hdl/fp_sequencer.sv
hdl/fp_datapath.sv
hdl/fpu_ctl_top.sv
verif/fp_checker.sv
verif/tb_fpu.sv

/* run.sh */
#!/bin/sh
# build and run the FPU control testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_fpu -o tb_fpu
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_fpu)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^RESULT: PASS$"; then
	exit 0
fi
exit 1

/* verif/fp_checker.sv */
// result checker for fpu_ctl_top; samples on the falling edge, memory copy covers 64 words only
`timescale 1ns/1ps
`include "fp_cfg.svh"

module fp_checker (
	input  logic                  clk_sys,
	input  logic                  _0_f,
	input  logic                  efp,
	input  fp_pkg::fp_op_t        op,
	input  logic [`FP_ADDR_W-1:0] arg_addr,
	input  logic                  mem_rd,
	input  logic                  mem_wr,
	input  logic [`FP_ADDR_W-1:0] mem_addr,
	input  logic [`FP_WORD_W-1:0] mem_rdata,
	input  logic [`FP_WORD_W-1:0] mem_wdata,
	input  logic                  mem_ok,
	input  logic                  ekc_fp,
	input  logic                  busy,
	input  logic                  ovf,
	output int                    n_jobs,
	output int                    n_err
);

	fp_pkg::fp_num_u acc;
	fp_pkg::fp_num_u arg;
	fp_pkg::fp_op_t job_op;
	logic [`FP_ADDR_W-1:0] job_addr;
	logic job_on;
	logic exp_ovf;
	bit job_ok;
	int n_rd;
	int n_wr;
	logic [`FP_WORD_W-1:0] mem_copy [64];
	bit mem_known [64];

	// ----------------------------------------------------------
	// reference arithmetic: align, add, normalize
	// ----------------------------------------------------------
	function automatic fp_pkg::fp_num_u arith_ref(input fp_pkg::fp_num_u a,
		input fp_pkg::fp_num_u b, input logic sub, output logic ovf_out);
		longint ma;
		longint mb;
		longint s;
		int ea;
		int eb;
		int e;
		fp_pkg::fp_num_u r;
		ma = longint'($signed(a.fields.mant));
		mb = longint'($signed(b.fields.mant));
		ea = int'($signed(a.fields.exp));
		eb = int'($signed(b.fields.exp));
		// smaller exponent moves right, far off leaves only the sign
		if (ea >= eb) begin
			mb = (ea - eb >= `FP_MANT_W) ? ((mb < 0) ? -64'sd1 : 64'sd0) : (mb >>> (ea - eb));
			e = ea;
		end else begin
			ma = (eb - ea >= `FP_MANT_W) ? ((ma < 0) ? -64'sd1 : 64'sd0) : (ma >>> (eb - ea));
			e = eb;
		end
		s = sub ? (ma - mb) : (ma + mb);
		ovf_out = 1'b0;
		// sum left the 40-bit range
		if (s >= (longint'(1) <<< 39) || s < -(longint'(1) <<< 39)) begin
			s = s >>> 1;
			e = e + 1;
			ovf_out = (e > `FP_EXP_MAX);
		end
		// top two bits equal means one more left shift
		while (!ovf_out && s >= -(longint'(1) <<< 38) && s < (longint'(1) <<< 38)) begin
			if (s == 0 || e - 1 < `FP_EXP_MIN) begin
				s = 0;
				e = 0;
				break;
			end
			s = s <<< 1;
			e = e - 1;
		end
		r.fields.mant = s[`FP_MANT_W-1:0];
		r.fields.exp = e[`FP_EXP_W-1:0];
		return r;
	endfunction

	task flag_error();
		n_err++;
		job_ok = 1'b0;
	endtask

	task check_transfer();
		int idx;
		int a;
		idx = n_rd + n_wr;
		a = int'(mem_addr[5:0]);
		if (!job_on) begin
			$display("memory access at %0t while no job was running", $time);
			flag_error();
			return;
		end
		if (idx >= `FP_WORDS) begin
			$display("job %0d made more than %0d memory accesses", n_jobs, `FP_WORDS);
			flag_error();
			return;
		end
		if (mem_addr != job_addr + 16'(idx)) begin
			$display("error at %0t: job %0d address %h, expected %h",
				$time, n_jobs, mem_addr, job_addr + 16'(idx));
			flag_error();
		end
		if (mem_rd) begin
			n_rd++;
			if (mem_known[a] && mem_rdata != mem_copy[a]) begin
				$display("error at %0t: address %h read back %h, last written %h",
					$time, mem_addr, mem_rdata, mem_copy[a]);
				flag_error();
			end
			if (job_op == fp_pkg::FP_LOAD)
				acc.words[idx] = mem_rdata;
			else
				arg.words[idx] = mem_rdata;
		end else begin
			n_wr++;
			if (mem_wdata != acc.words[idx]) begin
				$display("error at %0t: job %0d word %0d written %h, expected %h",
					$time, n_jobs, idx, mem_wdata, acc.words[idx]);
				flag_error();
			end
			mem_copy[a] = mem_wdata;
			mem_known[a] = 1'b1;
		end
	endtask

	task finish_job();
		fp_pkg::fp_num_u res;
		logic res_ovf;
		if (!job_on) begin
			$display("end pulse at %0t while no job was running", $time);
			flag_error();
			return;
		end
		if ((job_op == fp_pkg::FP_STORE) ? (n_wr != `FP_WORDS || n_rd != 0) :
			(n_rd != `FP_WORDS || n_wr != 0)) begin
			$display("job %0d ended after %0d reads and %0d writes", n_jobs, n_rd, n_wr);
			flag_error();
		end
		case (job_op)
			fp_pkg::FP_LOAD: exp_ovf = 1'b0;
			fp_pkg::FP_ADD, fp_pkg::FP_SUB: begin
				res = arith_ref(acc, arg, job_op == fp_pkg::FP_SUB, res_ovf);
				acc = res;
				exp_ovf = res_ovf;
			end
			default: ;
		endcase
		if (ovf !== exp_ovf) begin
			$display("error at %0t: job %0d ovf %b, expected %b", $time, n_jobs, ovf, exp_ovf);
			flag_error();
		end
		$display("job %0d %s: %s", n_jobs, job_op.name(), job_ok ? "ok" : "failed");
		job_on = 1'b0;
	endtask

	// ----------------------------------------------------------
	// bus watcher
	// ----------------------------------------------------------
	always @(negedge clk_sys) begin
		if (_0_f) begin
			acc = '0;
			job_on = 1'b0;
			exp_ovf = 1'b0;
		end else begin
			// busy trails the start strobe and the end pulse by one cycle
			if (busy !== job_on) begin
				$display("error at %0t: busy %b, expected %b", $time, busy, job_on);
				flag_error();
			end
			// strobes while a job runs must be dropped by the DUT
			if (efp && !job_on) begin
				job_on = 1'b1;
				job_op = op;
				job_addr = arg_addr;
				n_rd = 0;
				n_wr = 0;
				job_ok = 1'b1;
				n_jobs++;
			end
			if (mem_ok && (mem_rd || mem_wr))
				check_transfer();
			if (ekc_fp)
				finish_job();
		end
	end

endmodule

/* verif/tb_fpu.sv */
// testbench for fpu_ctl_top; 64-word memory with 1 to 6 cycles of random ack delay
`timescale 1ns/1ps
`include "fp_cfg.svh"

module tb_fpu;

	localparam int CLK_PERIOD = 40;
	localparam int N_JOBS = 37;
	localparam int JOB_CYCLES = 200;

	logic clk_sys = 1'b0;
	logic _0_f = 1'b1;
	logic efp = 1'b0;
	fp_pkg::fp_op_t op = fp_pkg::FP_LOAD;
	logic [`FP_ADDR_W-1:0] arg_addr = '0;
	logic [`FP_WORD_W-1:0] mem_rdata = '0;
	logic mem_ok = 1'b0;
	logic mem_rd;
	logic mem_wr;
	logic [`FP_ADDR_W-1:0] mem_addr;
	logic [`FP_WORD_W-1:0] mem_wdata;
	logic ekc_fp;
	logic busy;
	logic ovf;
	int n_jobs;
	int n_err;

	logic [`FP_WORD_W-1:0] mem [64];
	logic mem_pend = 1'b0;
	logic [2:0] mem_wait = '0;

	fpu_ctl_top dut (.*);
	fp_checker chk (.*);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	// ----------------------------------------------------------
	// memory model
	// ----------------------------------------------------------
	always @(posedge clk_sys) begin
		if (_0_f) begin
			mem_ok <= 1'b0;
			mem_pend <= 1'b0;
		end else if (mem_ok) begin
			mem_ok <= 1'b0;
		end else if (mem_rd || mem_wr) begin
			if (!mem_pend) begin
				mem_pend <= 1'b1;
				mem_wait <= 3'($urandom % 6);
			end else if (mem_wait != 0) begin
				mem_wait <= mem_wait - 1'b1;
			end else begin
				mem_pend <= 1'b0;
				mem_ok <= 1'b1;
				if (mem_wr)
					mem[mem_addr[5:0]] <= mem_wdata;
				else
					mem_rdata <= mem[mem_addr[5:0]];
			end
		end
	end

	// random normalized number, top two mantissa bits differ
	function automatic fp_pkg::fp_num_u make_norm(input int e);
		fp_pkg::fp_num_u n;
		logic s;
		s = 1'($urandom);
		n.fields.mant = {s, ~s, 6'($urandom), 32'($urandom)};
		n.fields.exp = 8'(e);
		return n;
	endfunction

	function automatic fp_pkg::fp_num_u make_num(input logic [`FP_MANT_W-1:0] m, input int e);
		fp_pkg::fp_num_u n;
		n.fields.mant = m;
		n.fields.exp = 8'(e);
		return n;
	endfunction

	task automatic put_num(input int addr, input fp_pkg::fp_num_u n);
		for (int i = 0; i < `FP_WORDS; i++)
			mem[addr + i] = n.words[i];
	endtask

	// one job, optionally with a stray start strobe while busy
	task automatic run_job(input fp_pkg::fp_op_t o, input int addr, input bit poke);
		@(posedge clk_sys);
		efp <= 1'b1;
		op <= o;
		arg_addr <= 16'(addr);
		@(posedge clk_sys);
		efp <= 1'b0;
		if (poke) begin
			repeat (3) @(posedge clk_sys);
			efp <= 1'b1;
			op <= fp_pkg::FP_STORE;
			arg_addr <= 16'd40;
			@(posedge clk_sys);
			efp <= 1'b0;
		end
		do @(negedge clk_sys); while (!ekc_fp);
	endtask

	task automatic arith_case(input fp_pkg::fp_num_u a, input fp_pkg::fp_num_u b,
		input fp_pkg::fp_op_t o, input bit poke);
		put_num(0, a);
		put_num(3, b);
		run_job(fp_pkg::FP_LOAD, 0, 1'b0);
		run_job(o, 3, poke);
		run_job(fp_pkg::FP_STORE, 8, 1'b0);
	endtask

	// ----------------------------------------------------------
	// job sequence
	// ----------------------------------------------------------
	initial begin
		int e;
		void'($urandom(32'h152c));
		for (int i = 0; i < 64; i++)
			mem[i] = 16'(i * 16'h9e37) ^ 16'h5a5a;
		repeat (2) @(posedge clk_sys);
		_0_f <= 1'b0;

		// round trip through the accumulator and back through memory
		put_num(0, make_norm(3));
		run_job(fp_pkg::FP_LOAD, 0, 1'b1);
		run_job(fp_pkg::FP_STORE, 8, 1'b0);
		run_job(fp_pkg::FP_LOAD, 8, 1'b0);
		run_job(fp_pkg::FP_STORE, 12, 1'b0);

		for (int i = 0; i < 4; i++) begin
			e = int'($urandom % 41) - 20;
			arith_case(make_norm(e), make_norm(e + int'($urandom % 9) - 4),
				fp_pkg::FP_ADD, i == 1);
		end

		// same exponents, so cancellation needs normalize steps
		for (int i = 0; i < 2; i++) begin
			e = int'($urandom % 41) - 20;
			arith_case(make_norm(e), make_norm(e), fp_pkg::FP_SUB, i == 0);
		end
		put_num(0, make_norm(7));
		run_job(fp_pkg::FP_LOAD, 0, 1'b0);
		run_job(fp_pkg::FP_SUB, 0, 1'b0);
		run_job(fp_pkg::FP_STORE, 8, 1'b0);

		// exponents 40 or more apart, both orders
		arith_case(make_norm(50), make_norm(5), fp_pkg::FP_ADD, 1'b0);
		arith_case(make_norm(-30), make_norm(20), fp_pkg::FP_ADD, 1'b0);

		// exponent overflow, then underflow to zero
		arith_case(make_num(40'h40_0000_0000, 127), make_num(40'h60_0000_0000, 127),
			fp_pkg::FP_ADD, 1'b0);
		arith_case(make_num(40'h40_0000_0000, -127), make_num(40'h40_0000_0001, -127),
			fp_pkg::FP_SUB, 1'b0);

		repeat (2) @(posedge clk_sys);
		$display("jobs run %0d of %0d, errors %0d", n_jobs, N_JOBS, n_err);
		if (n_err == 0 && n_jobs == N_JOBS) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	initial begin
		#(N_JOBS * JOB_CYCLES * CLK_PERIOD);
		$display("watchdog: jobs still running after %0d cycles", N_JOBS * JOB_CYCLES);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule
